// File: hw/cu_pkg.sv
package cu_pkg;

	// Datapath and field widths
	localparam int WORD_W     = 16;	// Data, PC and PSW width
	localparam int OP_W       = 7;	// Opcode field
	localparam int BUS_CTRL_W = 7;	// [6] W/B, [4:3] source, [1:0] destination
	localparam int RNUM_W     = 5;	// Register number incl. temp register
	localparam int ALU_OP_W   = 6;
	localparam int CYCLE_W    = 4;
	localparam int CNT_W      = 3;	// CEX true and false counts
	localparam int CEX_W      = 2 + 2 * CNT_W;	// Active, result, true count, false count
	localparam int FLAGS_W    = 5;	// PSW bits 4:0
	localparam int COND_W     = 4;
	localparam int FIELD_W    = 3;	// dst and srccon fields
	localparam int PSW_SRC_W  = 2;
	localparam int SXT_NUM_W  = 5;

	localparam logic [RNUM_W-1:0] REG_PC     = 5'd7;
	localparam logic [RNUM_W-1:0] REG_CONST2 = 5'd10;	// Constant 2 in the register file
	localparam logic [RNUM_W-1:0] REG_TEMP   = 5'd16;	// Hidden temp register for SWAP

	// Bus words, codes 0 MDR/MAR, 1 reg file, 2 IR, 3 ALU
	localparam logic [BUS_CTRL_W-1:0] BUS_IDLE       = 7'b1111111;	// Invalid, nothing moves
	localparam logic [BUS_CTRL_W-1:0] BUS_PC_TO_MAR  = 7'b0001000;
	localparam logic [BUS_CTRL_W-1:0] BUS_ALU_TO_REG = 7'b0011001;
	localparam logic [BUS_CTRL_W-1:0] BUS_MDR_TO_IR  = 7'b0000010;
	localparam logic [BUS_CTRL_W-1:0] BUS_REG_TO_REG = 7'b0001001;

	localparam logic [PSW_SRC_W-1:0] PSW_SRC_ALU  = 2'd0;
	localparam logic [PSW_SRC_W-1:0] PSW_SRC_IDLE = 2'd3;	// No PSW update

	localparam logic [ALU_OP_W-1:0] ALU_ADD = 6'd0;

	localparam logic [CYCLE_W-1:0] CYC_FETCH   = 4'd1;
	localparam logic [CYCLE_W-1:0] CYC_INC_PC  = 4'd2;
	localparam logic [CYCLE_W-1:0] CYC_LOAD_IR = 4'd3;
	localparam logic [CYCLE_W-1:0] CYC_DECODE  = 4'd4;
	localparam logic [CYCLE_W-1:0] CYC_EXEC    = 4'd5;
	localparam logic [CYCLE_W-1:0] CYC_EXEC2   = 4'd6;
	localparam logic [CYCLE_W-1:0] CYC_EXEC3   = 4'd7;

	localparam logic [OP_W-1:0] OP_BEQ   = 7'd1;
	localparam logic [OP_W-1:0] OP_BGE   = 7'd6;	// First branch of the upper code group
	localparam logic [OP_W-1:0] OP_BRA   = 7'd8;
	localparam logic [OP_W-1:0] OP_ADD   = 7'd9;
	localparam logic [OP_W-1:0] OP_BIS   = 7'd20;
	localparam logic [OP_W-1:0] OP_MOV   = 7'd21;
	localparam logic [OP_W-1:0] OP_SWAP  = 7'd22;
	localparam logic [OP_W-1:0] OP_SRA   = 7'd23;
	localparam logic [OP_W-1:0] OP_RRC   = 7'd24;
	localparam logic [OP_W-1:0] OP_SETCC = 7'd29;
	localparam logic [OP_W-1:0] OP_CLRCC = 7'd30;
	localparam logic [OP_W-1:0] OP_CEX   = 7'd31;

	localparam int PSW_C = 0;
	localparam int PSW_Z = 1;
	localparam int PSW_N = 2;
	localparam int PSW_V = 4;

	localparam logic [SXT_NUM_W-1:0] SXT_BRANCH_BIT = 5'd10;	// Sign bit of branch offset
	localparam logic [COND_W-1:0] BRANCH_CODE_LOW  = 4'd1;	// Opcodes 1..5 to codes 0..4
	localparam logic [COND_W-1:0] BRANCH_CODE_HIGH = 4'd4;	// Opcodes 6..8 to codes 10..12

	localparam logic [COND_W-1:0] COND_EQ = 4'd0;
	localparam logic [COND_W-1:0] COND_NE = 4'd1;
	localparam logic [COND_W-1:0] COND_CS = 4'd2;
	localparam logic [COND_W-1:0] COND_CC = 4'd3;
	localparam logic [COND_W-1:0] COND_MI = 4'd4;
	localparam logic [COND_W-1:0] COND_PL = 4'd5;
	localparam logic [COND_W-1:0] COND_VS = 4'd6;
	localparam logic [COND_W-1:0] COND_VC = 4'd7;
	localparam logic [COND_W-1:0] COND_HI = 4'd8;
	localparam logic [COND_W-1:0] COND_LS = 4'd9;
	localparam logic [COND_W-1:0] COND_GE = 4'd10;
	localparam logic [COND_W-1:0] COND_LT = 4'd11;
	localparam logic [COND_W-1:0] COND_GT = 4'd12;
	localparam logic [COND_W-1:0] COND_LE = 4'd13;
	localparam logic [COND_W-1:0] COND_AL = 4'd14;

endpackage

// File: hw/cond_eval.sv
module cond_eval (
	input  logic [cu_pkg::COND_W-1:0]  code,
	input  logic [cu_pkg::FLAGS_W-1:0] flags,
	output logic                       taken
);
	import cu_pkg::*;

	logic c;
	logic z;
	logic n;
	logic v;

	assign c = flags[PSW_C];
	assign z = flags[PSW_Z];
	assign n = flags[PSW_N];
	assign v = flags[PSW_V];

	always_comb
	begin
		case (code)
			COND_EQ: taken = z;
			COND_NE: taken = !z;
			COND_CS: taken = c;	// Also HS
			COND_CC: taken = !c;	// Also LO
			COND_MI: taken = n;
			COND_PL: taken = !n;
			COND_VS: taken = v;
			COND_VC: taken = !v;
			COND_HI: taken = c && !z;
			COND_LS: taken = !c || z;
			COND_GE: taken = (n == v);
			COND_LT: taken = (n != v);
			COND_GT: taken = !z && (n == v);
			COND_LE: taken = z || (n != v);
			COND_AL: taken = 1'b1;
			default: taken = 1'b0;	// Code 15 never passes
		endcase
	end

endmodule

// File: hw/cycle_sequencer.sv
module cycle_sequencer (
	input  logic                       clock,
	input  logic                       cpucycle_rst,
	input  logic                       restart,
	input  logic [cu_pkg::WORD_W-1:0]  pc,
	input  logic [cu_pkg::WORD_W-1:0]  brkpnt,
	output logic [cu_pkg::CYCLE_W-1:0] cycle,
	output logic                       breakpnt_set
);
	import cu_pkg::*;

	logic brk_hit;	// PC sits on the breakpoint at fetch

	assign brk_hit = (cycle == CYC_FETCH) && (pc == brkpnt);

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			cycle        <= CYC_FETCH;
			breakpnt_set <= 1'b0;
		end
		else
		begin
			breakpnt_set <= brk_hit;	// Drops once pc moves off brkpnt
			if (breakpnt_set || brk_hit)
			begin
				cycle <= cycle;	// Halted at fetch
			end
			else if (restart)
			begin
				cycle <= CYC_FETCH;	// Next instruction
			end
			else
			begin
				cycle <= cycle + 1'b1;
			end
		end
	end

endmodule

// File: hw/cex_tracker.sv
module cex_tracker (
	input  logic                       clock,
	input  logic                       cpucycle_rst,
	input  logic [cu_pkg::CYCLE_W-1:0] cycle,
	input  logic                       cex_load,
	input  logic [cu_pkg::COND_W-1:0]  cond,
	input  logic [cu_pkg::CNT_W-1:0]   t_count,
	input  logic [cu_pkg::CNT_W-1:0]   f_count,
	input  logic [cu_pkg::WORD_W-1:0]  psw_in,
	output logic                       decode_allow,
	output logic [cu_pkg::CEX_W-1:0]   cex_state
);
	import cu_pkg::*;

	logic             cex_active;	// CEX block in progress
	logic             cex_result;	// Condition outcome at load
	logic [CNT_W-1:0] t_cnt;
	logic [CNT_W-1:0] f_cnt;
	logic [CNT_W-1:0] t_next;
	logic [CNT_W-1:0] f_next;
	logic             cond_taken;

	cond_eval u_cond (
		.code  (cond),
		.flags (psw_in[FLAGS_W-1:0]),
		.taken (cond_taken)
	);

	// True side drains first, then the false side
	assign t_next = (t_cnt != '0) ? t_cnt - 1'b1 : t_cnt;
	assign f_next = (t_cnt == '0 && f_cnt != '0) ? f_cnt - 1'b1 : f_cnt;

	assign decode_allow = !cex_active
		|| (cex_result && t_cnt != '0)
		|| (!cex_result && t_cnt == '0 && f_cnt != '0);

	assign cex_state = {cex_active, cex_result, t_cnt, f_cnt};

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			cex_active <= 1'b0;
			cex_result <= 1'b0;
			t_cnt      <= '0;
			f_cnt      <= '0;
		end
		else if (cex_load)
		begin
			cex_active <= 1'b1;
			cex_result <= cond_taken;
			t_cnt      <= t_count;
			f_cnt      <= f_count;
		end
		else if (cycle == CYC_DECODE)
		begin
			t_cnt      <= t_next;
			f_cnt      <= f_next;
			cex_active <= cex_active && (t_next != '0 || f_next != '0);	// Block done at zero
		end
	end

endmodule

// File: hw/microop_control.sv
module microop_control (
	input  logic                          clock,
	input  logic                          cpucycle_rst,
	input  logic [cu_pkg::CYCLE_W-1:0]    cycle,
	input  logic                          breakpnt_set,
	input  logic                          decode_allow,
	input  logic [cu_pkg::OP_W-1:0]       op,
	input  logic [cu_pkg::FIELD_W-1:0]    dst,
	input  logic [cu_pkg::FIELD_W-1:0]    srccon,
	input  logic                          wb,
	input  logic                          rc,
	input  logic [cu_pkg::FLAGS_W-1:0]    pswb,
	input  logic [cu_pkg::WORD_W-1:0]     psw_in,
	output logic                          id_en,
	output logic                          psw_update,
	output logic                          s_bus_ctrl,
	output logic                          sxt_bus_ctrl,
	output logic                          sxt_shift,
	output logic [cu_pkg::BUS_CTRL_W-1:0] data_bus_ctrl,
	output logic [cu_pkg::BUS_CTRL_W-1:0] addr_bus_ctrl,
	output logic [cu_pkg::PSW_SRC_W-1:0]  psw_bus_ctrl,
	output logic [cu_pkg::SXT_NUM_W-1:0]  sxt_bit_num,
	output logic [cu_pkg::ALU_OP_W-1:0]   alu_op,
	output logic [cu_pkg::RNUM_W-1:0]     dbus_rnum_dst,
	output logic [cu_pkg::RNUM_W-1:0]     dbus_rnum_src,
	output logic [cu_pkg::RNUM_W-1:0]     alu_rnum_dst,
	output logic [cu_pkg::RNUM_W-1:0]     alu_rnum_src,
	output logic [cu_pkg::RNUM_W-1:0]     addr_rnum_src,
	output logic [cu_pkg::WORD_W-1:0]     psw_out,
	output logic                          restart,
	output logic                          cex_load
);
	import cu_pkg::*;

	logic [COND_W-1:0]     branch_code;	// Branch opcode mapped onto condition table
	logic                  branch_taken;
	logic [OP_W-1:0]       alu_idx;	// ALU function index before the W/B bit
	logic [BUS_CTRL_W-1:0] bus_wb;	// W/B bit placed in a bus word
	logic [RNUM_W-1:0]     dst_rnum;
	logic [RNUM_W-1:0]     src_rnum;
	logic [RNUM_W-1:0]     alu_src_rnum;	// srccon or constant bank via rc

	assign branch_code = (op < OP_BGE) ? op[COND_W-1:0] - BRANCH_CODE_LOW
		: op[COND_W-1:0] + BRANCH_CODE_HIGH;

	cond_eval u_branch_cond (
		.code  (branch_code),
		.flags (psw_in[FLAGS_W-1:0]),
		.taken (branch_taken)
	);

	// Shifts continue the ALU code space right after BIS
	assign alu_idx = (op <= OP_BIS) ? op - OP_ADD : op - OP_SRA + OP_BIS - OP_ADD + 7'd1;

	assign bus_wb       = {wb, {(BUS_CTRL_W-1){1'b0}}};
	assign dst_rnum     = {{(RNUM_W-FIELD_W){1'b0}}, dst};
	assign src_rnum     = {{(RNUM_W-FIELD_W){1'b0}}, srccon};
	assign alu_src_rnum = {{(RNUM_W-FIELD_W-1){1'b0}}, rc, srccon};

	// Restart takes effect at the edge that ends the current cycle
	always_comb
	begin
		restart = 1'b0;
		if (cycle == CYC_DECODE)
		begin
			restart = !decode_allow;	// Skipped by CEX
		end
		else if (cycle == CYC_EXEC)
		begin
			restart = (op != OP_SWAP);	// Only SWAP runs past execute
		end
		else if (cycle > CYC_EXEC2)
		begin
			restart = 1'b1;
		end
	end

	assign cex_load = (cycle == CYC_EXEC) && (op == OP_CEX);

	// Flag register follows psw_in except after SETCC/CLRCC
	always_ff @(posedge clock)
	begin
		psw_out <= psw_in;
		if (cycle == CYC_EXEC && op == OP_SETCC)
		begin
			psw_out[FLAGS_W-1:0] <= psw_in[FLAGS_W-1:0] | pswb;
		end
		else if (cycle == CYC_EXEC && op == OP_CLRCC)
		begin
			psw_out[FLAGS_W-1:0] <= psw_in[FLAGS_W-1:0] & ~pswb;
		end
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			id_en         <= 1'b0;
			psw_update    <= 1'b0;
			data_bus_ctrl <= BUS_IDLE;
			addr_bus_ctrl <= BUS_IDLE;
			psw_bus_ctrl  <= PSW_SRC_IDLE;
		end
		else
		begin
			id_en         <= 1'b0;	// Strobes and bus words last one clock
			psw_update    <= 1'b0;
			data_bus_ctrl <= BUS_IDLE;
			addr_bus_ctrl <= BUS_IDLE;
			psw_bus_ctrl  <= PSW_SRC_IDLE;
			if (!breakpnt_set)
			begin
				case (cycle)
					CYC_FETCH:
					begin
						addr_rnum_src <= REG_PC;	// PC onto address bus
						addr_bus_ctrl <= BUS_PC_TO_MAR;
						alu_rnum_dst  <= REG_PC;	// Set up PC + 2
						alu_rnum_src  <= REG_CONST2;
						dbus_rnum_dst <= REG_PC;
						alu_op        <= ALU_ADD;
						s_bus_ctrl    <= 1'b0;
					end
					CYC_INC_PC:
						data_bus_ctrl <= BUS_ALU_TO_REG;	// Write incremented PC
					CYC_LOAD_IR:
						data_bus_ctrl <= BUS_MDR_TO_IR;
					CYC_DECODE:
						id_en <= decode_allow;
					CYC_EXEC:
					begin
						case (op) inside
							[OP_BEQ:OP_BRA]:
							begin
								if (branch_taken)
								begin
									sxt_bit_num   <= SXT_BRANCH_BIT;
									sxt_shift     <= 1'b1;	// Word offset
									sxt_bus_ctrl  <= 1'b1;	// Offset from decoder
									s_bus_ctrl    <= 1'b1;	// Extended offset into ALU
									alu_op        <= ALU_ADD;
									alu_rnum_dst  <= REG_PC;
									dbus_rnum_dst <= REG_PC;
									data_bus_ctrl <= BUS_ALU_TO_REG;
								end
							end
							[OP_ADD:OP_BIS], OP_SRA, OP_RRC:
							begin
								alu_op        <= {alu_idx[ALU_OP_W-2:0], wb};
								alu_rnum_dst  <= dst_rnum;
								alu_rnum_src  <= alu_src_rnum;
								dbus_rnum_dst <= dst_rnum;
								psw_update    <= 1'b1;
								psw_bus_ctrl  <= PSW_SRC_ALU;
								data_bus_ctrl <= BUS_ALU_TO_REG | bus_wb;
							end
							OP_MOV:
							begin
								dbus_rnum_dst <= dst_rnum;
								dbus_rnum_src <= src_rnum;
								data_bus_ctrl <= BUS_REG_TO_REG | bus_wb;
							end
							OP_SWAP:
							begin
								dbus_rnum_dst <= REG_TEMP;	// Save src first
								dbus_rnum_src <= src_rnum;
								data_bus_ctrl <= BUS_REG_TO_REG;
							end
							default: ;	// SETCC/CLRCC/CEX act outside the bus words
						endcase
					end
					CYC_EXEC2:
					begin
						if (op == OP_SWAP)
						begin
							dbus_rnum_dst <= src_rnum;	// dst into src
							dbus_rnum_src <= dst_rnum;
							data_bus_ctrl <= BUS_REG_TO_REG;
						end
					end
					CYC_EXEC3:
					begin
						if (op == OP_SWAP)
						begin
							dbus_rnum_dst <= dst_rnum;	// Saved value into dst
							dbus_rnum_src <= REG_TEMP;
							data_bus_ctrl <= BUS_REG_TO_REG;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// File: hw/control_unit.sv
module control_unit (
	input  logic                          clock,
	input  logic                          cpucycle_rst,
	input  logic [cu_pkg::WORD_W-1:0]     pc,
	input  logic [cu_pkg::WORD_W-1:0]     brkpnt,
	input  logic [cu_pkg::OP_W-1:0]       op,
	input  logic [cu_pkg::COND_W-1:0]     cond,
	input  logic [cu_pkg::CNT_W-1:0]      t_count,
	input  logic [cu_pkg::CNT_W-1:0]      f_count,
	input  logic [cu_pkg::FLAGS_W-1:0]    pswb,
	input  logic [cu_pkg::FIELD_W-1:0]    dst,
	input  logic [cu_pkg::FIELD_W-1:0]    srccon,
	input  logic                          wb,
	input  logic                          rc,
	input  logic [cu_pkg::WORD_W-1:0]     psw_in,
	output logic                          id_en,
	output logic                          psw_update,
	output logic                          s_bus_ctrl,
	output logic                          sxt_bus_ctrl,
	output logic                          sxt_shift,
	output logic                          breakpnt_set,
	output logic [cu_pkg::BUS_CTRL_W-1:0] data_bus_ctrl,
	output logic [cu_pkg::BUS_CTRL_W-1:0] addr_bus_ctrl,
	output logic [cu_pkg::PSW_SRC_W-1:0]  psw_bus_ctrl,
	output logic [cu_pkg::SXT_NUM_W-1:0]  sxt_bit_num,
	output logic [cu_pkg::ALU_OP_W-1:0]   alu_op,
	output logic [cu_pkg::RNUM_W-1:0]     dbus_rnum_dst,
	output logic [cu_pkg::RNUM_W-1:0]     dbus_rnum_src,
	output logic [cu_pkg::RNUM_W-1:0]     alu_rnum_dst,
	output logic [cu_pkg::RNUM_W-1:0]     alu_rnum_src,
	output logic [cu_pkg::RNUM_W-1:0]     addr_rnum_src,
	output logic [cu_pkg::WORD_W-1:0]     psw_out,
	output logic [cu_pkg::CYCLE_W-1:0]    cycle,
	output logic [cu_pkg::CEX_W-1:0]      cex_state_out
);

	logic restart;	// End of instruction
	logic cex_load;	// CEX executing this cycle
	logic decode_allow;	// Not skipped by CEX

	cycle_sequencer u_seq (
		.clock        (clock),
		.cpucycle_rst (cpucycle_rst),
		.restart      (restart),
		.pc           (pc),
		.brkpnt       (brkpnt),
		.cycle        (cycle),
		.breakpnt_set (breakpnt_set)
	);

	cex_tracker u_cex (
		.clock        (clock),
		.cpucycle_rst (cpucycle_rst),
		.cycle        (cycle),
		.cex_load     (cex_load),
		.cond         (cond),
		.t_count      (t_count),
		.f_count      (f_count),
		.psw_in       (psw_in),
		.decode_allow (decode_allow),
		.cex_state    (cex_state_out)
	);

	microop_control u_uop (
		.clock         (clock),
		.cpucycle_rst  (cpucycle_rst),
		.cycle         (cycle),
		.breakpnt_set  (breakpnt_set),
		.decode_allow  (decode_allow),
		.op            (op),
		.dst           (dst),
		.srccon        (srccon),
		.wb            (wb),
		.rc            (rc),
		.pswb          (pswb),
		.psw_in        (psw_in),
		.id_en         (id_en),
		.psw_update    (psw_update),
		.s_bus_ctrl    (s_bus_ctrl),
		.sxt_bus_ctrl  (sxt_bus_ctrl),
		.sxt_shift     (sxt_shift),
		.data_bus_ctrl (data_bus_ctrl),
		.addr_bus_ctrl (addr_bus_ctrl),
		.psw_bus_ctrl  (psw_bus_ctrl),
		.sxt_bit_num   (sxt_bit_num),
		.alu_op        (alu_op),
		.dbus_rnum_dst (dbus_rnum_dst),
		.dbus_rnum_src (dbus_rnum_src),
		.alu_rnum_dst  (alu_rnum_dst),
		.alu_rnum_src  (alu_rnum_src),
		.addr_rnum_src (addr_rnum_src),
		.psw_out       (psw_out),
		.restart       (restart),
		.cex_load      (cex_load)
	);

endmodule

// File: testbench/tb_clock.sv
module tb_clock (
	output logic clock,
	output logic cpucycle_rst
);

	initial
	begin
		clock        = 1'b0;
		cpucycle_rst = 1'b1;
		repeat (4) @(posedge clock);	// Four reset cycles
		@(negedge clock);	// Release with the other inputs
		cpucycle_rst = 1'b0;
	end

	always #20 clock = ~clock;	// Period 40

endmodule

// File: testbench/tb_control_unit.sv
module tb_control_unit;
	import cu_pkg::*;

	localparam int N_INSTR   = 1 + 14 + 4 + 24 + 28 + 6 + 3 + 1 + 1;	// Instructions issued
	localparam int CLK_LIMIT = 8 * N_INSTR + 50;
	localparam int K_NONE    = 0;	// Which held fields the cycle drives
	localparam int K_FETCH   = 1;
	localparam int K_BRANCH  = 2;
	localparam int K_ALU     = 3;
	localparam int K_MOVE    = 4;

	logic clock;
	logic cpucycle_rst;
	logic [WORD_W-1:0] pc, brkpnt, psw_in;
	logic [OP_W-1:0] op;
	logic [COND_W-1:0] cond;
	logic [CNT_W-1:0] t_count, f_count;
	logic [FLAGS_W-1:0] pswb;
	logic [FIELD_W-1:0] dst, srccon;
	logic wb, rc;
	logic id_en, psw_update, s_bus_ctrl, sxt_bus_ctrl, sxt_shift, breakpnt_set;
	logic [BUS_CTRL_W-1:0] data_bus_ctrl, addr_bus_ctrl;
	logic [PSW_SRC_W-1:0] psw_bus_ctrl;
	logic [SXT_NUM_W-1:0] sxt_bit_num;
	logic [ALU_OP_W-1:0] alu_op;
	logic [RNUM_W-1:0] dbus_rnum_dst, dbus_rnum_src, alu_rnum_dst, alu_rnum_src, addr_rnum_src;
	logic [WORD_W-1:0] psw_out;
	logic [CYCLE_W-1:0] cycle;
	logic [CEX_W-1:0] cex_state_out;

	logic [CYCLE_W-1:0] m_cycle;	// Reference sequencer and CEX state
	logic m_brk, m_act, m_res;
	logic [CNT_W-1:0] m_t, m_f;
	logic [BUS_CTRL_W-1:0] e_data, e_addr;	// Expected after the next edge
	logic [PSW_SRC_W-1:0] e_psw_src;
	logic e_id, e_pswu, e_s_bus;
	logic [WORD_W-1:0] e_psw;
	logic [ALU_OP_W-1:0] e_alu_op;
	logic [RNUM_W-1:0] e_alu_dst, e_alu_src, e_db_dst, e_db_src;
	int e_kind;
	logic have_exp = 1'b0;	// No expectation before the first edge
	int clk_count = 0;
	logic [15:0] lfsr_state = 16'd22;

	tb_clock u_clk (
		.clock        (clock),
		.cpucycle_rst (cpucycle_rst)
	);

	control_unit dut (
		.clock         (clock),
		.cpucycle_rst  (cpucycle_rst),
		.pc            (pc),
		.brkpnt        (brkpnt),
		.op            (op),
		.cond          (cond),
		.t_count       (t_count),
		.f_count       (f_count),
		.pswb          (pswb),
		.dst           (dst),
		.srccon        (srccon),
		.wb            (wb),
		.rc            (rc),
		.psw_in        (psw_in),
		.id_en         (id_en),
		.psw_update    (psw_update),
		.s_bus_ctrl    (s_bus_ctrl),
		.sxt_bus_ctrl  (sxt_bus_ctrl),
		.sxt_shift     (sxt_shift),
		.breakpnt_set  (breakpnt_set),
		.data_bus_ctrl (data_bus_ctrl),
		.addr_bus_ctrl (addr_bus_ctrl),
		.psw_bus_ctrl  (psw_bus_ctrl),
		.sxt_bit_num   (sxt_bit_num),
		.alu_op        (alu_op),
		.dbus_rnum_dst (dbus_rnum_dst),
		.dbus_rnum_src (dbus_rnum_src),
		.alu_rnum_dst  (alu_rnum_dst),
		.alu_rnum_src  (alu_rnum_src),
		.addr_rnum_src (addr_rnum_src),
		.psw_out       (psw_out),
		.cycle         (cycle),
		.cex_state_out (cex_state_out)
	);

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);	// Galois form, maximal length
	endfunction

	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);	// One step per bit
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Condition table over C Z N V
	function automatic logic cond_ref(input logic [COND_W-1:0] code, input logic [FLAGS_W-1:0] f);
		logic c, z, n, v;
		c = f[0];
		z = f[1];
		n = f[2];
		v = f[4];
		case (code)
			4'd0: return z;
			4'd1: return !z;
			4'd2: return c;
			4'd3: return !c;
			4'd4: return n;
			4'd5: return !n;
			4'd6: return v;
			4'd7: return !v;
			4'd8: return c && !z;
			4'd9: return !c || z;
			4'd10: return n == v;
			4'd11: return n != v;
			4'd12: return !z && (n == v);
			4'd13: return z || (n != v);
			4'd14: return 1'b1;
			default: return 1'b0;	// Code 15
		endcase
	endfunction

	// Expected words for the current reference cycle, returns restart
	function automatic logic ref_outputs();
		logic allow;
		logic restart;
		logic [COND_W-1:0] code;
		int off;
		allow = !m_act || (m_res && m_t != '0) || (!m_res && m_t == '0 && m_f != '0);
		restart   = 1'b0;
		e_id      = 1'b0;
		e_pswu    = 1'b0;
		e_data    = BUS_IDLE;
		e_addr    = BUS_IDLE;
		e_psw_src = PSW_SRC_IDLE;
		e_kind    = K_NONE;
		e_psw     = psw_in;	// Flag register tracks psw_in
		if (m_cycle == CYC_EXEC && op == OP_SETCC)
			e_psw[FLAGS_W-1:0] = psw_in[FLAGS_W-1:0] | pswb;
		else if (m_cycle == CYC_EXEC && op == OP_CLRCC)
			e_psw[FLAGS_W-1:0] = psw_in[FLAGS_W-1:0] & ~pswb;
		if (cpucycle_rst || m_brk)
			return 1'b0;	// Inactive words only
		case (m_cycle)
			CYC_FETCH:
			begin
				e_addr    = BUS_PC_TO_MAR;
				e_kind    = K_FETCH;
				e_alu_op  = '0;	// Add
				e_alu_dst = REG_PC;
				e_alu_src = REG_CONST2;
				e_s_bus   = 1'b0;
			end
			CYC_INC_PC: e_data = BUS_ALU_TO_REG;
			CYC_LOAD_IR: e_data = BUS_MDR_TO_IR;
			CYC_DECODE:
			begin
				e_id    = allow;
				restart = !allow;	// Skipped instruction
			end
			CYC_EXEC:
			begin
				restart = (op != OP_SWAP);
				if (op >= 7'd1 && op <= 7'd8)
				begin
					code = (op < 7'd6) ? op[3:0] - 4'd1 : op[3:0] + 4'd4;
					if (cond_ref(code, psw_in[FLAGS_W-1:0]))
					begin
						e_kind    = K_BRANCH;
						e_data    = BUS_ALU_TO_REG;
						e_s_bus   = 1'b1;
						e_alu_dst = REG_PC;
						e_db_dst  = REG_PC;
					end
				end
				else if ((op >= 7'd9 && op <= 7'd20) || op == 7'd23 || op == 7'd24)
				begin
					off       = (op <= 7'd20) ? int'(op) - 9 : int'(op) - 11;
					e_kind    = K_ALU;
					e_alu_op  = ALU_OP_W'(2 * off + int'(wb));
					e_alu_dst = RNUM_W'(dst);
					e_alu_src = RNUM_W'(int'(srccon) + 8 * int'(rc));
					e_db_dst  = RNUM_W'(dst);
					e_pswu    = 1'b1;
					e_psw_src = PSW_SRC_ALU;
					e_data    = BUS_ALU_TO_REG;
					e_data[6] = wb;
				end
				else if (op == 7'd21)
				begin
					e_kind    = K_MOVE;
					e_db_dst  = RNUM_W'(dst);
					e_db_src  = RNUM_W'(srccon);
					e_data    = BUS_REG_TO_REG;
					e_data[6] = wb;
				end
				else if (op == 7'd22)
				begin
					e_kind   = K_MOVE;	// srccon into temp
					e_db_dst = REG_TEMP;
					e_db_src = RNUM_W'(srccon);
					e_data   = BUS_REG_TO_REG;
				end
			end
			CYC_EXEC2:
			begin
				if (op == 7'd22)
				begin
					e_kind   = K_MOVE;	// dst into srccon
					e_db_dst = RNUM_W'(srccon);
					e_db_src = RNUM_W'(dst);
					e_data   = BUS_REG_TO_REG;
				end
			end
			CYC_EXEC3:
			begin
				restart  = 1'b1;
				e_kind   = K_MOVE;	// Temp into dst
				e_db_dst = RNUM_W'(dst);
				e_db_src = REG_TEMP;
				e_data   = BUS_REG_TO_REG;
			end
			default: restart = 1'b1;
		endcase
		return restart;
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
		$display("MISMATCH at time %0t: %s is %h, expected %h", $time, what, got, exp);
		$display("tests failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp)
			report_mismatch(what, 32'(got), 32'(exp));
	endtask

	task automatic check_bus_word(input string what, input logic [BUS_CTRL_W-1:0] got,
		input logic [BUS_CTRL_W-1:0] exp);
		if (got !== exp)
			report_mismatch(what, 32'(got), 32'(exp));
	endtask

	task automatic check_rnum(input string what, input logic [RNUM_W-1:0] got,
		input logic [RNUM_W-1:0] exp);
		if (got !== exp)
			report_mismatch(what, 32'(got), 32'(exp));
	endtask

	task automatic check_psw(input string what, input logic [WORD_W-1:0] got,
		input logic [WORD_W-1:0] exp);
		if (got !== exp)
			report_mismatch(what, 32'(got), 32'(exp));
	endtask

	task automatic check_cycle(input string what, input logic [CYCLE_W-1:0] got,
		input logic [CYCLE_W-1:0] exp);
		if (got !== exp)
			report_mismatch(what, 32'(got), 32'(exp));
	endtask

	task automatic check_alu_op(input string what, input logic [ALU_OP_W-1:0] got,
		input logic [ALU_OP_W-1:0] exp);
		if (got !== exp)
			report_mismatch(what, 32'(got), 32'(exp));
	endtask

	task automatic check_psw_src(input string what, input logic [PSW_SRC_W-1:0] got,
		input logic [PSW_SRC_W-1:0] exp);
		if (got !== exp)
			report_mismatch(what, 32'(got), 32'(exp));
	endtask

	task automatic check_sxt_num(input string what, input logic [SXT_NUM_W-1:0] got,
		input logic [SXT_NUM_W-1:0] exp);
		if (got !== exp)
			report_mismatch(what, 32'(got), 32'(exp));
	endtask

	task automatic check_cex(input string what, input logic [CEX_W-1:0] got,
		input logic [CEX_W-1:0] exp);
		if (got !== exp)
			report_mismatch(what, 32'(got), 32'(exp));
	endtask

	// Registered outputs still hold what the previous edge produced
	task automatic compare_outputs();
		check_cycle("cycle", cycle, m_cycle);
		check_bit("breakpnt_set", breakpnt_set, m_brk);
		check_cex("cex_state_out", cex_state_out, {m_act, m_res, m_t, m_f});
		check_bit("id_en", id_en, e_id);
		check_bit("psw_update", psw_update, e_pswu);
		check_bus_word("data_bus_ctrl", data_bus_ctrl, e_data);
		check_bus_word("addr_bus_ctrl", addr_bus_ctrl, e_addr);
		check_psw_src("psw_bus_ctrl", psw_bus_ctrl, e_psw_src);
		check_psw("psw_out", psw_out, e_psw);
		if (e_kind == K_FETCH || e_kind == K_ALU)
		begin
			check_alu_op("alu_op", alu_op, e_alu_op);
			check_rnum("alu_rnum_src", alu_rnum_src, e_alu_src);
		end
		if (e_kind == K_FETCH || e_kind == K_BRANCH || e_kind == K_ALU)
			check_rnum("alu_rnum_dst", alu_rnum_dst, e_alu_dst);
		if (e_kind == K_FETCH || e_kind == K_BRANCH)
			check_bit("s_bus_ctrl", s_bus_ctrl, e_s_bus);
		if (e_kind == K_FETCH)
			check_rnum("addr_rnum_src", addr_rnum_src, REG_PC);
		if (e_kind == K_BRANCH)
		begin
			check_sxt_num("sxt_bit_num", sxt_bit_num, SXT_BRANCH_BIT);
			check_bit("sxt_shift", sxt_shift, 1'b1);
			check_bit("sxt_bus_ctrl", sxt_bus_ctrl, 1'b1);
		end
		if (e_kind == K_BRANCH || e_kind == K_ALU || e_kind == K_MOVE)
			check_rnum("dbus_rnum_dst", dbus_rnum_dst, e_db_dst);
		if (e_kind == K_MOVE)
			check_rnum("dbus_rnum_src", dbus_rnum_src, e_db_src);
	endtask

	// Compare, then step the reference model across this edge
	always @(posedge clock)
	begin
		logic restart;
		logic hit;
		if (have_exp)
			compare_outputs();
		restart = ref_outputs();
		if (cpucycle_rst)
		begin
			m_cycle = CYC_FETCH;
			m_brk   = 1'b0;
			m_act   = 1'b0;
			m_res   = 1'b0;
			m_t     = '0;
			m_f     = '0;
		end
		else
		begin
			hit = (m_cycle == CYC_FETCH) && (pc == brkpnt);
			if (m_cycle == CYC_EXEC && op == OP_CEX)
			begin
				m_act = 1'b1;
				m_res = cond_ref(cond, psw_in[FLAGS_W-1:0]);
				m_t   = t_count;
				m_f   = f_count;
			end
			else if (m_cycle == CYC_DECODE)
			begin
				if (m_t != '0)
					m_t = m_t - 3'd1;	// True side first
				else if (m_f != '0)
					m_f = m_f - 3'd1;
				m_act = m_act && (m_t != '0 || m_f != '0);
			end
			if (!(m_brk || hit))
				m_cycle = restart ? CYC_FETCH : m_cycle + 4'd1;
			m_brk = hit;
		end
		have_exp = 1'b1;
	end

	always @(posedge clock)
	begin
		clk_count = clk_count + 1;
		if (clk_count > CLK_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d clocks", CLK_LIMIT);
			$display("tests failed");
			$fatal(1, "timeout");
		end
	end

	task automatic wait_done();
		do @(negedge clock); while (cycle == CYC_FETCH);
		do @(negedge clock); while (cycle != CYC_FETCH);	// Back at the next fetch
	endtask

	// Fields change only at a falling edge while cycle is at fetch
	task automatic run_instr(input logic [OP_W-1:0] opc);
		while (cycle != CYC_FETCH)
			@(negedge clock);
		op     = opc;
		dst    = FIELD_W'(take_bits(3));
		srccon = FIELD_W'(take_bits(3));
		wb     = take_bits(1) != 16'd0;
		rc     = take_bits(1) != 16'd0;
		pswb   = FLAGS_W'(take_bits(5));
		psw_in = take_bits(16);
		pc     = pc + 16'd2;
		wait_done();
	endtask

	initial
	begin
		int k;
		pc      = 16'h0100;
		brkpnt  = 16'hFFFF;
		op      = '0;	// Unused opcode runs first
		cond    = '0;
		t_count = '0;
		f_count = '0;
		pswb    = '0;
		dst     = '0;
		srccon  = '0;
		wb      = 1'b0;
		rc      = 1'b0;
		psw_in  = '0;
		do @(posedge clock); while (cpucycle_rst);
		@(negedge clock);
		for (k = 9; k <= 20; k++)
			run_instr(OP_W'(k));
		run_instr(OP_SRA);
		run_instr(OP_RRC);
		repeat (4) run_instr(OP_MOV);
		repeat (3)
		begin
			for (k = 1; k <= 8; k++)
				run_instr(OP_W'(k));	// BEQ to BRA, random flags
		end
		repeat (4)
		begin
			cond    = COND_W'(take_bits(4));
			t_count = CNT_W'(take_bits(2));	// Block fits in six followers
			f_count = CNT_W'(take_bits(2));
			run_instr(OP_CEX);
			for (k = 0; k < 6; k++)
				run_instr(k[0] ? OP_ADD : OP_MOV);
		end
		repeat (3)
		begin
			run_instr(OP_SETCC);
			run_instr(OP_CLRCC);
		end
		repeat (3) run_instr(OP_SWAP);
		op     = OP_MOV;	// Halt on this fetch
		brkpnt = pc;
		repeat (4) @(negedge clock);
		if (!(breakpnt_set === 1'b1 && cycle === CYC_FETCH))
			report_failure("Breakpoint did not halt the unit at fetch");
		pc = pc + 16'd2;	// Leave the breakpoint
		wait_done();
		run_instr(7'd40);
		repeat (2) @(negedge clock);
		$display("all tests passed");
		$finish;
	end

endmodule

// File: tb.f
hw/cu_pkg.sv
hw/cond_eval.sv
hw/cycle_sequencer.sv
hw/cex_tracker.sv
hw/microop_control.sv
hw/control_unit.sv
testbench/tb_clock.sv
testbench/tb_control_unit.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_control_unit
FILELIST  = tb.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
